/* common/unlock_macros.svh */
`ifndef UNLOCK_MACROS_SVH
`define UNLOCK_MACROS_SVH

`define UNLOCK_WORD_W 32 // key word and bus data width
`define UNLOCK_MEM_DEPTH 16 // key store words

// key store map
`define UNLOCK_ADR_EXP 0 // private exponent d
`define UNLOCK_ADR_MOD 1 // modulus n
`define UNLOCK_ADR_CT 2 // ciphertext c0..c3 at 2..5
`define UNLOCK_ADR_PT 6 // plaintext p0..p3 at 6..9

`define UNLOCK_KEY_WORDS 4 // wrapped aes key words
`define UNLOCK_LOAD_WORDS 6 // d, n, c0..c3

`endif

/* common/unlock_pkg.sv */
`include "unlock_macros.svh"

package unlock_pkg;

	typedef logic [`UNLOCK_WORD_W-1:0] key_word_t; // one key or bus word

	// top level phases, one start pulse on each entry
	typedef enum logic [2:0] {
		LOAD, // buffering d, n and ciphertext
		CRYPT, // modexp running
		EMIT, // plaintext going out
		PASS, // all words delivered
		FAIL // modulus rejected
	} phase_t;

endpackage

/* common/wb_pkg.sv */
`include "unlock_macros.svh"

package wb_pkg;

	localparam int WB_MASTERS = 3; // loader, engine, streamer

	typedef logic [$clog2(`UNLOCK_MEM_DEPTH)-1:0] wb_adr_t; // word address
	typedef logic [$clog2(WB_MASTERS)-1:0] master_t; // owner index

endpackage

/* hdl/key_out_streamer.sv */
`timescale 1ns/1ns
`include "unlock_macros.svh"

module key_out_streamer (
	input logic clk,
	input logic rst,
	input logic start_i,
	output logic done_o,
	output unlock_pkg::key_word_t out_data_o,
	output logic out_valid_o,
	input logic out_ready_i,
	output logic wb_cyc_o,
	output logic wb_stb_o,
	output logic wb_we_o,
	output wb_pkg::wb_adr_t wb_adr_o,
	input unlock_pkg::key_word_t wb_dat_i,
	input logic wb_ack_i
);
	typedef enum logic [1:0] {S_IDLE, S_BUS, S_OUT} sstate_t;

	sstate_t st_q;
	logic [1:0] cnt_q; // plaintext word 0..3
	logic bus_q; // read cycle open
	logic last; // final word on the output

	assign last = (cnt_q == 2'(`UNLOCK_KEY_WORDS - 1));
	assign wb_cyc_o = bus_q;
	assign wb_stb_o = bus_q;
	assign wb_we_o = 1'b0; // read only master
	assign wb_adr_o = wb_pkg::wb_adr_t'(`UNLOCK_ADR_PT + cnt_q);
	assign out_valid_o = (st_q == S_OUT); // held until handshake
	assign done_o = (st_q == S_OUT) & out_ready_i & last; // same cycle as 4th handshake

	always_ff @(posedge clk) begin
		if (rst) begin
			st_q <= S_IDLE;
			cnt_q <= '0;
			bus_q <= 1'b0;
		end else begin
			case (st_q)
				S_IDLE: if (start_i) begin
					cnt_q <= '0;
					bus_q <= 1'b1;
					st_q <= S_BUS;
				end
				S_BUS: if (wb_ack_i) begin
					bus_q <= 1'b0;
					st_q <= S_OUT;
				end
				S_OUT: if (out_ready_i) begin
					if (last)
						st_q <= S_IDLE;
					else begin
						cnt_q <= cnt_q + 2'd1;
						bus_q <= 1'b1; // fetch next word
						st_q <= S_BUS;
					end
				end
				default: st_q <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (st_q == S_BUS && wb_ack_i)
			out_data_o <= wb_dat_i;
	end

endmodule

/* hdl/key_store_ram.sv */
`timescale 1ns/1ns
`include "unlock_macros.svh"

module key_store_ram (
	input logic clk,
	input logic rst,
	input logic wb_cyc_i,
	input logic wb_stb_i,
	input logic wb_we_i,
	input wb_pkg::wb_adr_t wb_adr_i,
	input unlock_pkg::key_word_t wb_dat_i,
	output unlock_pkg::key_word_t wb_dat_o,
	output logic wb_ack_o
);
	unlock_pkg::key_word_t mem [`UNLOCK_MEM_DEPTH]; // d, n, ct, pt
	logic take; // access accepted this cycle

	assign take = wb_cyc_i & wb_stb_i & ~wb_ack_o; // no back to back ack on held stb

	always_ff @(posedge clk) begin
		if (rst)
			wb_ack_o <= 1'b0;
		else
			wb_ack_o <= take; // single cycle ack
	end

	always_ff @(posedge clk) begin
		if (take) begin
			if (wb_we_i)
				mem[wb_adr_i] <= wb_dat_i;
			wb_dat_o <= mem[wb_adr_i]; // read data lines up with ack
		end
	end

endmodule

/* hdl/rsa_unlock_top.sv */
`timescale 1ns/1ns

module rsa_unlock_top (
	input logic clk,
	input logic rst,
	input unlock_pkg::key_word_t in_data_i,
	input logic in_valid_i,
	output logic in_ready_o,
	output unlock_pkg::key_word_t out_data_o,
	output logic out_valid_o,
	input logic out_ready_i,
	output logic led_pass_o,
	output logic led_fail_o
);
	// bus masters: 0 loader, 1 engine, 2 streamer
	logic [wb_pkg::WB_MASTERS-1:0] m_cyc;
	logic [wb_pkg::WB_MASTERS-1:0] m_stb;
	logic [wb_pkg::WB_MASTERS-1:0] m_we;
	logic [wb_pkg::WB_MASTERS-1:0] m_ack;
	wb_pkg::wb_adr_t [wb_pkg::WB_MASTERS-1:0] m_adr;
	unlock_pkg::key_word_t [wb_pkg::WB_MASTERS-1:0] m_dat_w;
	unlock_pkg::key_word_t [wb_pkg::WB_MASTERS-1:0] m_dat_r;
	logic s_cyc, s_stb, s_we, s_ack;
	wb_pkg::wb_adr_t s_adr;
	unlock_pkg::key_word_t s_dat_w, s_dat_r;
	logic load_start, load_done, crypt_start, crypt_done, bad_mod, emit_start, emit_done;

	assign m_dat_w[2] = '0; // streamer never writes

	unlock_sequencer seq_i (.clk(clk), .rst(rst), .in_valid_i(in_valid_i),
		.load_start_o(load_start), .load_done_i(load_done),
		.crypt_start_o(crypt_start), .crypt_done_i(crypt_done), .bad_mod_i(bad_mod),
		.emit_start_o(emit_start), .emit_done_i(emit_done),
		.led_pass_o(led_pass_o), .led_fail_o(led_fail_o));

	stream_loader loader_i (.clk(clk), .rst(rst), .start_i(load_start),
		.in_data_i(in_data_i), .in_valid_i(in_valid_i), .in_ready_o(in_ready_o),
		.done_o(load_done), .wb_cyc_o(m_cyc[0]), .wb_stb_o(m_stb[0]), .wb_we_o(m_we[0]),
		.wb_adr_o(m_adr[0]), .wb_dat_o(m_dat_w[0]), .wb_ack_i(m_ack[0]));

	modexp_engine engine_i (.clk(clk), .rst(rst), .start_i(crypt_start),
		.done_o(crypt_done), .bad_mod_o(bad_mod),
		.wb_cyc_o(m_cyc[1]), .wb_stb_o(m_stb[1]), .wb_we_o(m_we[1]), .wb_adr_o(m_adr[1]),
		.wb_dat_o(m_dat_w[1]), .wb_dat_i(m_dat_r[1]), .wb_ack_i(m_ack[1]));

	key_out_streamer streamer_i (.clk(clk), .rst(rst), .start_i(emit_start),
		.done_o(emit_done), .out_data_o(out_data_o), .out_valid_o(out_valid_o),
		.out_ready_i(out_ready_i), .wb_cyc_o(m_cyc[2]), .wb_stb_o(m_stb[2]),
		.wb_we_o(m_we[2]), .wb_adr_o(m_adr[2]), .wb_dat_i(m_dat_r[2]), .wb_ack_i(m_ack[2]));

	wb_arbiter arb_i (.clk(clk), .rst(rst), .m_cyc_i(m_cyc), .m_stb_i(m_stb),
		.m_we_i(m_we), .m_adr_i(m_adr), .m_dat_i(m_dat_w), .m_ack_o(m_ack),
		.m_dat_o(m_dat_r), .s_cyc_o(s_cyc), .s_stb_o(s_stb), .s_we_o(s_we),
		.s_adr_o(s_adr), .s_dat_o(s_dat_w), .s_dat_i(s_dat_r), .s_ack_i(s_ack));

	key_store_ram ram_i (.clk(clk), .rst(rst), .wb_cyc_i(s_cyc), .wb_stb_i(s_stb),
		.wb_we_i(s_we), .wb_adr_i(s_adr), .wb_dat_i(s_dat_w), .wb_dat_o(s_dat_r),
		.wb_ack_o(s_ack));

endmodule

/* hdl/stream_loader.sv */
`timescale 1ns/1ns
`include "unlock_macros.svh"

module stream_loader (
	input logic clk,
	input logic rst,
	input logic start_i,
	input unlock_pkg::key_word_t in_data_i,
	input logic in_valid_i,
	output logic in_ready_o,
	output logic done_o,
	output logic wb_cyc_o,
	output logic wb_stb_o,
	output logic wb_we_o,
	output wb_pkg::wb_adr_t wb_adr_o,
	output unlock_pkg::key_word_t wb_dat_o,
	input logic wb_ack_i
);
	typedef enum logic [1:0] {L_IDLE, L_WAIT, L_BUS} lstate_t;

	lstate_t st_q;
	logic [2:0] cnt_q; // word index 0..5
	logic bus_q; // write cycle open
	unlock_pkg::key_word_t word_q; // accepted word

	assign in_ready_o = (st_q == L_WAIT); // low during the bus write
	assign wb_cyc_o = bus_q;
	assign wb_stb_o = bus_q;
	assign wb_we_o = 1'b1; // write only master
	assign wb_adr_o = wb_pkg::wb_adr_t'(`UNLOCK_ADR_EXP + cnt_q); // d first
	assign wb_dat_o = word_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			st_q <= L_IDLE;
			cnt_q <= '0;
			bus_q <= 1'b0;
			done_o <= 1'b0;
		end else begin
			done_o <= 1'b0;
			case (st_q)
				L_IDLE: if (start_i) begin
					cnt_q <= '0;
					st_q <= L_WAIT;
				end
				L_WAIT: if (in_valid_i) begin // handshake
					bus_q <= 1'b1;
					st_q <= L_BUS;
				end
				L_BUS: if (wb_ack_i) begin
					bus_q <= 1'b0;
					if (cnt_q == 3'(`UNLOCK_LOAD_WORDS - 1)) begin
						done_o <= 1'b1; // whole key set stored
						st_q <= L_IDLE;
					end else begin
						cnt_q <= cnt_q + 3'd1;
						st_q <= L_WAIT;
					end
				end
				default: st_q <= L_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (in_ready_o && in_valid_i)
			word_q <= in_data_i;
	end

endmodule

/* hdl/unlock_sequencer.sv */
`timescale 1ns/1ns

module unlock_sequencer (
	input logic clk,
	input logic rst,
	input logic in_valid_i,
	output logic load_start_o,
	input logic load_done_i,
	output logic crypt_start_o,
	input logic crypt_done_i,
	input logic bad_mod_i,
	output logic emit_start_o,
	input logic emit_done_i,
	output logic led_pass_o,
	output logic led_fail_o
);
	unlock_pkg::phase_t phase_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			phase_q <= unlock_pkg::LOAD;
			load_start_o <= 1'b1; // first load kicks off as reset releases
			crypt_start_o <= 1'b0;
			emit_start_o <= 1'b0;
			led_pass_o <= 1'b0;
			led_fail_o <= 1'b0;
		end else begin
			load_start_o <= 1'b0; // starts are single pulses
			crypt_start_o <= 1'b0;
			emit_start_o <= 1'b0;
			case (phase_q)
				unlock_pkg::LOAD: if (load_done_i) begin
					crypt_start_o <= 1'b1;
					phase_q <= unlock_pkg::CRYPT;
				end
				unlock_pkg::CRYPT: begin
					if (bad_mod_i) begin // rejected modulus, nothing emitted
						led_fail_o <= 1'b1;
						phase_q <= unlock_pkg::FAIL;
					end else if (crypt_done_i) begin
						emit_start_o <= 1'b1;
						phase_q <= unlock_pkg::EMIT;
					end
				end
				unlock_pkg::EMIT: if (emit_done_i) begin
					led_pass_o <= 1'b1;
					phase_q <= unlock_pkg::PASS;
				end
				unlock_pkg::PASS, unlock_pkg::FAIL: if (in_valid_i) begin // next key set
					led_pass_o <= 1'b0;
					led_fail_o <= 1'b0;
					load_start_o <= 1'b1;
					phase_q <= unlock_pkg::LOAD;
				end
				default: phase_q <= unlock_pkg::LOAD;
			endcase
		end
	end

endmodule

/* hdl/wb_arbiter.sv */
`timescale 1ns/1ns

module wb_arbiter (
	input logic clk,
	input logic rst,
	input logic [wb_pkg::WB_MASTERS-1:0] m_cyc_i,
	input logic [wb_pkg::WB_MASTERS-1:0] m_stb_i,
	input logic [wb_pkg::WB_MASTERS-1:0] m_we_i,
	input wb_pkg::wb_adr_t [wb_pkg::WB_MASTERS-1:0] m_adr_i,
	input unlock_pkg::key_word_t [wb_pkg::WB_MASTERS-1:0] m_dat_i,
	output logic [wb_pkg::WB_MASTERS-1:0] m_ack_o,
	output unlock_pkg::key_word_t [wb_pkg::WB_MASTERS-1:0] m_dat_o,
	output logic s_cyc_o,
	output logic s_stb_o,
	output logic s_we_o,
	output wb_pkg::wb_adr_t s_adr_o,
	output unlock_pkg::key_word_t s_dat_o,
	input unlock_pkg::key_word_t s_dat_i,
	input logic s_ack_i
);
	wb_pkg::master_t gnt_q; // owner, kept as rr pointer when idle
	logic gnt_vld_q; // someone owns the bus
	wb_pkg::master_t cand; // candidate in search
	wb_pkg::master_t nxt_gnt;
	logic nxt_vld;

	// search starts after the last owner, last owner itself has lowest priority
	always_comb begin
		nxt_gnt = gnt_q;
		nxt_vld = 1'b0;
		cand = gnt_q;
		for (int k = wb_pkg::WB_MASTERS; k >= 1; k--) begin
			cand = wb_pkg::master_t'((int'(gnt_q) + k) % wb_pkg::WB_MASTERS);
			if (m_cyc_i[cand]) begin
				nxt_gnt = cand; // nearest requester wins
				nxt_vld = 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			gnt_q <= wb_pkg::master_t'(wb_pkg::WB_MASTERS - 1); // master 0 goes first
			gnt_vld_q <= 1'b0;
		end else if (!gnt_vld_q || !m_cyc_i[gnt_q]) begin // rearbitrate on cyc drop only
			gnt_vld_q <= nxt_vld;
			if (nxt_vld)
				gnt_q <= nxt_gnt;
		end
	end

	assign s_cyc_o = gnt_vld_q & m_cyc_i[gnt_q];
	assign s_stb_o = gnt_vld_q & m_stb_i[gnt_q];
	assign s_we_o = m_we_i[gnt_q];
	assign s_adr_o = m_adr_i[gnt_q];
	assign s_dat_o = m_dat_i[gnt_q];

	always_comb begin
		for (int i = 0; i < wb_pkg::WB_MASTERS; i++) begin
			m_ack_o[i] = s_ack_i & gnt_vld_q & (gnt_q == wb_pkg::master_t'(i)); // owner only
			m_dat_o[i] = s_dat_i;
		end
	end

endmodule

/* modexp/modexp_engine.sv */
`timescale 1ns/1ns
`include "unlock_macros.svh"

module modexp_engine (
	input logic clk,
	input logic rst,
	input logic start_i,
	output logic done_o,
	output logic bad_mod_o,
	output logic wb_cyc_o,
	output logic wb_stb_o,
	output logic wb_we_o,
	output wb_pkg::wb_adr_t wb_adr_o,
	output unlock_pkg::key_word_t wb_dat_o,
	input unlock_pkg::key_word_t wb_dat_i,
	input logic wb_ack_i
);
	typedef enum logic [2:0] {E_IDLE, E_RD_D, E_RD_N, E_CHK, E_RD_C, E_EXP, E_MUL, E_WR} est_t;
	typedef enum logic [1:0] {J_RED, J_MULR, J_SQR} job_t; // what a product feeds

	est_t st_q;
	job_t job_q;
	logic bus_q; // bus cycle open
	logic acked;
	logic [1:0] idx_q; // ciphertext word
	logic [4:0] step_q; // product bit step
	logic r_done_q; // multiply for this exponent bit done
	unlock_pkg::key_word_t d_q, n_q, e_q; // exponent, modulus, shifting exponent
	unlock_pkg::key_word_t r_q, b_q; // result and running base
	unlock_pkg::key_word_t mul_a_q, mul_b_q, acc_q, mm_next;
	logic [`UNLOCK_WORD_W:0] dbl, dbl_r, add, add_r; // 33 bit, both stay below 2n

	// one shift-add step of a*b mod n, a scanned msb first
	assign dbl = {acc_q, 1'b0};
	assign dbl_r = (dbl >= {1'b0, n_q}) ? dbl - {1'b0, n_q} : dbl;
	assign add = dbl_r + {1'b0, mul_b_q};
	assign add_r = (add >= {1'b0, n_q}) ? add - {1'b0, n_q} : add;
	assign mm_next = mul_a_q[`UNLOCK_WORD_W-1] ? add_r[`UNLOCK_WORD_W-1:0]
		: dbl_r[`UNLOCK_WORD_W-1:0];

	assign acked = bus_q & wb_ack_i;
	assign wb_cyc_o = bus_q;
	assign wb_stb_o = bus_q;
	assign wb_we_o = (st_q == E_WR);
	assign wb_dat_o = r_q; // plaintext writeback

	always_comb begin
		case (st_q)
			E_RD_N: wb_adr_o = wb_pkg::wb_adr_t'(`UNLOCK_ADR_MOD);
			E_RD_C: wb_adr_o = wb_pkg::wb_adr_t'(`UNLOCK_ADR_CT + idx_q);
			E_WR: wb_adr_o = wb_pkg::wb_adr_t'(`UNLOCK_ADR_PT + idx_q);
			default: wb_adr_o = wb_pkg::wb_adr_t'(`UNLOCK_ADR_EXP);
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			st_q <= E_IDLE;
			bus_q <= 1'b0;
			done_o <= 1'b0;
			bad_mod_o <= 1'b0;
		end else begin
			done_o <= 1'b0;
			bad_mod_o <= 1'b0;
			if (st_q inside {E_RD_D, E_RD_N, E_RD_C, E_WR} && !bus_q)
				bus_q <= 1'b1; // open on the first cycle of a bus state
			if (acked)
				bus_q <= 1'b0; // one idle cycle between accesses
			case (st_q)
				E_IDLE: if (start_i) begin
					idx_q <= '0;
					st_q <= E_RD_D;
				end
				E_RD_D: if (acked) begin
					d_q <= wb_dat_i;
					st_q <= E_RD_N;
				end
				E_RD_N: if (acked) begin
					n_q <= wb_dat_i;
					st_q <= E_CHK;
				end
				E_CHK: begin
					if (!n_q[0] || n_q < 3) begin // even, 1 or 0
						bad_mod_o <= 1'b1;
						st_q <= E_IDLE;
					end else
						st_q <= E_RD_C;
				end
				E_RD_C: if (acked) begin
					mul_a_q <= wb_dat_i; // c * 1 mod n reduces c
					mul_b_q <= unlock_pkg::key_word_t'(1);
					acc_q <= '0;
					step_q <= '0;
					job_q <= J_RED;
					e_q <= d_q;
					r_q <= unlock_pkg::key_word_t'(1);
					r_done_q <= 1'b0;
					st_q <= E_MUL;
				end
				E_EXP: begin // right to left square and multiply
					acc_q <= '0;
					step_q <= '0;
					mul_b_q <= b_q;
					if (e_q == '0)
						st_q <= E_WR;
					else begin
						if (e_q[0] && !r_done_q) begin
							mul_a_q <= r_q; // r = r*b
							job_q <= J_MULR;
						end else begin
							mul_a_q <= b_q; // b = b*b
							job_q <= J_SQR;
						end
						st_q <= E_MUL;
					end
				end
				E_MUL: begin
					acc_q <= mm_next;
					mul_a_q <= mul_a_q << 1;
					step_q <= step_q + 5'd1;
					if (step_q == 5'd31) begin // 32nd step
						case (job_q)
							J_MULR: begin
								r_q <= mm_next;
								r_done_q <= 1'b1;
							end
							J_SQR: begin
								b_q <= mm_next;
								e_q <= e_q >> 1; // next exponent bit
								r_done_q <= 1'b0;
							end
							default: b_q <= mm_next; // reduced base
						endcase
						st_q <= E_EXP;
					end
				end
				E_WR: if (acked) begin
					if (idx_q == 2'(`UNLOCK_KEY_WORDS - 1)) begin
						done_o <= 1'b1;
						st_q <= E_IDLE;
					end else begin
						idx_q <= idx_q + 2'd1;
						st_q <= E_RD_C;
					end
				end
				default: st_q <= E_IDLE;
			endcase
		end
	end

endmodule

/* run.sh */
#!/bin/sh
# build tb_top with Verilator, run it, and look for the pass line in the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_top -o tb_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^Result: PASSED$" sim.log; then
	exit 0
fi
echo "pass line not found in sim.log"
exit 1

/* tb.f */
+incdir+common
common/unlock_pkg.sv
common/wb_pkg.sv
hdl/key_store_ram.sv
hdl/wb_arbiter.sv
hdl/stream_loader.sv
modexp/modexp_engine.sv
hdl/key_out_streamer.sv
hdl/unlock_sequencer.sv
hdl/rsa_unlock_top.sv
verification/unlock_properties.sv
verification/tb_top.sv

/* verification/tb_top.sv */
`timescale 1ns/1ns
`include "unlock_macros.svh"

module tb_top;
	localparam int SETS = 6; // key sets in the run
	localparam int KW = `UNLOCK_KEY_WORDS;
	localparam int LIMIT = SETS * KW * 33 * 2 * 40 * 2; // products per set, doubled for margin

	logic clk;
	logic rst;
	unlock_pkg::key_word_t in_data;
	logic in_valid;
	logic in_ready;
	unlock_pkg::key_word_t out_data;
	logic out_valid;
	logic out_ready;
	logic led_pass;
	logic led_fail;

	unlock_pkg::key_word_t exp_words [SETS*KW]; // expected plaintext, in output order
	unlock_pkg::key_word_t exp_head; // word due next on the output
	unlock_pkg::key_word_t keys [KW]; // ciphertext of the current set
	int exp_wr; // words queued by the model
	int exp_rd; // words seen on the output
	int cycles; // watchdog count
	logic expect_fail; // current set has a bad modulus
	logic seen_input; // any in_valid since reset

	rsa_unlock_top dut_i (.clk(clk), .rst(rst), .in_data_i(in_data), .in_valid_i(in_valid),
		.in_ready_o(in_ready), .out_data_o(out_data), .out_valid_o(out_valid),
		.out_ready_i(out_ready), .led_pass_o(led_pass), .led_fail_o(led_fail));

	assign exp_head = exp_words[exp_rd];

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("Result: FAILED");
		$fatal(1, "simulation stopped on first error");
	endtask

	// plain 64 bit square and multiply, products never overflow for n below 2^32
	function automatic unlock_pkg::key_word_t modpow(input logic [63:0] c, input logic [63:0] d,
		input logic [63:0] n);
		logic [63:0] r;
		logic [63:0] b;
		logic [63:0] e;
		r = 64'd1;
		b = c % n;
		e = d;
		while (e != 64'd0) begin
			if (e[0])
				r = (r * b) % n;
			b = (b * b) % n;
			e = e >> 1;
		end
		return r[31:0];
	endfunction

	task automatic send_word(input unlock_pkg::key_word_t w);
		logic ready_now;
		in_valid = 1'b0;
		repeat ($urandom % 3) begin // random idle gap
			@(posedge clk);
			#1;
		end
		in_data = w;
		in_valid = 1'b1;
		do begin
			ready_now = in_ready; // only depends on loader state, stable until the edge
			@(posedge clk);
			#1;
		end while (!ready_now);
		in_valid = 1'b0;
	endtask

	task automatic run_key_set(input unlock_pkg::key_word_t d, input unlock_pkg::key_word_t n,
		input logic bad);
		expect_fail = bad;
		if (!bad) begin
			for (int i = 0; i < KW; i++) begin
				exp_words[exp_wr] = modpow(64'(keys[i]), 64'(d), 64'(n)); // model result
				exp_wr++;
			end
		end
		send_word(d);
		send_word(n);
		for (int i = 0; i < KW; i++)
			send_word(keys[i]);
		wait (led_pass || led_fail); // watchdog catches a hang
		@(posedge clk); // LED checks sample this set before the next one starts
		#1;
	endtask

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin
		out_ready = 1'b0;
		forever begin
			@(posedge clk);
			#1 out_ready = ($urandom % 4) != 0; // ready about three cycles in four
		end
	end

	always @(posedge clk) begin
		if (rst) begin
			exp_rd <= 0;
			seen_input <= 1'b0;
			cycles <= 0;
		end else begin
			if (out_valid && out_ready)
				exp_rd <= exp_rd + 1; // one word delivered
			if (in_valid)
				seen_input <= 1'b1;
			cycles <= cycles + 1;
			if (cycles >= LIMIT)
				stop_with_failure($sformatf("timeout: no result after %0d cycles", cycles));
		end
	end

	a_reset_exit: assert property (@(posedge clk)
		$fell(rst) |-> !in_ready && !out_valid && !led_pass && !led_fail)
		else stop_with_failure("outputs were not idle right after reset");
	a_quiet_start: assert property (@(posedge clk) disable iff (rst)
		!seen_input |-> !out_valid && !led_pass && !led_fail)
		else stop_with_failure("output or LED active before any input word");
	a_out_word: assert property (@(posedge clk) disable iff (rst)
		out_valid && out_ready |-> exp_rd < exp_wr && out_data == exp_head)
		else stop_with_failure($sformatf("FAIL %0t out_data_o expected %h actual %h",
			$time, $sampled(exp_head), $sampled(out_data)));
	a_pass_led: assert property (@(posedge clk) disable iff (rst)
		$rose(led_pass) |-> !expect_fail && exp_rd == exp_wr)
		else stop_with_failure("pass LED lit for a bad modulus or before all words were out");
	a_fail_led: assert property (@(posedge clk) disable iff (rst)
		$rose(led_fail) |-> expect_fail)
		else stop_with_failure("fail LED lit for a valid modulus");
	a_fail_quiet: assert property (@(posedge clk) disable iff (rst)
		led_fail |-> !out_valid)
		else stop_with_failure("output valid while the fail LED is lit");
	a_led_clear: assert property (@(posedge clk) disable iff (rst)
		in_ready |-> !led_pass && !led_fail)
		else stop_with_failure("LED still lit while a new key set loads");

	initial begin
		void'($urandom(32'hca63_5be1));
		rst = 1'b1;
		in_data = '0;
		in_valid = 1'b0;
		exp_wr = 0;
		expect_fail = 1'b0;
		repeat (3) @(posedge clk);
		#1 rst = 1'b0;
		keys = '{32'd0, 32'd1, 32'd2, 32'd5}; // includes c above n
		run_key_set(32'd1, 32'd3, 1'b0); // smallest legal modulus
		for (int i = 0; i < KW; i++)
			keys[i] = $urandom;
		run_key_set($urandom, 32'h7fff_ffff, 1'b0); // large n, random d, clears pass LED
		run_key_set(32'h0001_0001, 32'h0000_1000, 1'b1); // even modulus
		run_key_set(32'd7, 32'd1, 1'b1); // modulus of one
		for (int i = 0; i < KW; i++)
			keys[i] = $urandom;
		run_key_set(32'h0001_0001, ($urandom | 32'h4000_0001) & 32'h7fff_ffff, 1'b0);
		keys = '{32'd65, 32'd3232, 32'd1, 32'd1000};
		run_key_set(32'd2753, 32'd3233, 1'b0); // 61 * 53 textbook pair
		if (exp_rd == exp_wr) begin
			$display("Result: PASSED");
			$finish;
		end else
			stop_with_failure("run ended with plaintext words still outstanding");
	end

endmodule

/* verification/unlock_properties.sv */
`timescale 1ns/1ns

module unlock_properties (
	input logic clk,
	input logic rst,
	input logic [wb_pkg::WB_MASTERS-1:0] m_stb_i,
	input logic [wb_pkg::WB_MASTERS-1:0] m_ack_i,
	input logic s_stb_i,
	input logic s_ack_i,
	input unlock_pkg::key_word_t out_data_i,
	input logic out_valid_i,
	input logic out_ready_i,
	input unlock_pkg::phase_t phase_i
);
	a_one_owner: assert property (@(posedge clk) disable iff (rst)
		s_ack_i |-> $onehot(m_ack_i))
		else $error("key store ack not routed to exactly one master");
	a_slave_ack: assert property (@(posedge clk) disable iff (rst) s_ack_i |-> s_stb_i)
		else $error("key store ack without strobe");

	for (genvar i = 0; i < wb_pkg::WB_MASTERS; i++) begin : g_master
		a_ack_stb: assert property (@(posedge clk) disable iff (rst) m_ack_i[i] |-> m_stb_i[i])
			else $error("master %0d got ack without strobe", i);
		a_stb_hold: assert property (@(posedge clk) disable iff (rst)
			m_stb_i[i] && !m_ack_i[i] |=> m_stb_i[i])
			else $error("master %0d dropped strobe before ack", i);
	end

	a_out_hold: assert property (@(posedge clk) disable iff (rst)
		out_valid_i && !out_ready_i |=> out_valid_i && $stable(out_data_i))
		else $error("output word changed under back-pressure");
	a_out_phase: assert property (@(posedge clk) disable iff (rst)
		out_valid_i |-> phase_i == unlock_pkg::EMIT)
		else $error("output valid outside EMIT phase");

endmodule

bind rsa_unlock_top unlock_properties props_i (.clk(clk), .rst(rst),
	.m_stb_i(m_stb), .m_ack_i(m_ack), .s_stb_i(s_stb), .s_ack_i(s_ack),
	.out_data_i(out_data_o), .out_valid_i(out_valid_o), .out_ready_i(out_ready_i),
	.phase_i(seq_i.phase_q));
